//--- run_sim.sh
#!/bin/sh
# builds the XR memory testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f xrmem.f --top-module tb_xrmem

./obj_dir/Vtb_xrmem > sim.log 2>&1
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    echo "xrmem: pass"
    exit 0
else
    echo "xrmem: fail"
    exit 1
fi

//--- src/xr_dpram.sv
/* synchronous block RAM with one read and one write port
   instanced for every XR memory at its own depth and width */

`timescale 1ns/10ps

module xr_dpram #(
    parameter int AWIDTH = 8,
    parameter int DWIDTH = 16
) (
    input  logic              clk,
    input  logic              rd_en_i,
    input  logic [AWIDTH-1:0] rd_addr_i,
    output logic [DWIDTH-1:0] rd_data_o,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  logic [DWIDTH-1:0] wr_data_i
);

    localparam int DEPTH = 1 << AWIDTH;

    logic [DWIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // output register holds its value while idle
    // same-address write gives the old word here
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

//--- src/xreg_file.sv
/* XR register file on the arbiter's register bus
   sixteen words, cleared by reset, read without a clock */

`timescale 1ns/10ps

`include "xrmem_macros.svh"

module xreg_file (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                wr_i,
    input  xrmem_pkg::xr_addr_t addr_i,
    input  xrmem_pkg::xr_word_t wdata_i,
    output xrmem_pkg::xr_word_t rdata_o
);

    import xrmem_pkg::*;

    localparam int IDX_W = $clog2(`XREG_COUNT);

    xr_word_t         regs [`XREG_COUNT];
    logic [IDX_W-1:0] idx;

    // upper address bits ignored
    // registers repeat every 16 addresses
    assign idx = addr_i[IDX_W-1:0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `XREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i) begin
            regs[idx] <= wdata_i;
        end
    end

    // combinational read so the arbiter can capture it on accept
    assign rdata_o = regs[idx];

endmodule

//--- src/xrmem_arb.sv
/* XR memory arbiter between host, copper and video requesters
   owns the color, tile and copper RAMs and drives the register file bus */

`timescale 1ns/10ps

`include "xrmem_macros.svh"

module xrmem_arb (
    input  logic                   clk,
    input  logic                   arst_n_i,

    // host XR port
    input  logic                   xr_sel_i,
    input  logic                   xr_wr_i,
    input  xrmem_pkg::xr_addr_t    xr_addr_i,
    input  xrmem_pkg::xr_word_t    xr_data_i,
    output logic                   xr_ack_o,
    output xrmem_pkg::xr_word_t    xr_data_o,

    // copper XR port, writes only
    input  logic                   copp_xr_sel_i,
    input  xrmem_pkg::xr_addr_t    copp_xr_addr_i,
    input  xrmem_pkg::xr_word_t    copp_xr_data_i,
    output logic                   copp_xr_ack_o,

    // video read ports
    input  logic                   vgen_color_sel_i,
    input  xrmem_pkg::color_addr_t vgen_color_addr_i,
    output xrmem_pkg::xr_word_t    vgen_color_data_o,
    input  logic                   vgen_tile_sel_i,
    input  xrmem_pkg::tile_addr_t  vgen_tile_addr_i,
    output xrmem_pkg::xr_word_t    vgen_tile_data_o,
    input  logic                   copp_prog_sel_i,
    input  xrmem_pkg::copp_addr_t  copp_prog_addr_i,
    output xrmem_pkg::copp_word_t  copp_prog_data_o,

    // register file bus
    output logic                   xreg_wr_o,
    output xrmem_pkg::xr_addr_t    xreg_addr_o,
    output xrmem_pkg::xr_word_t    xreg_wdata_o,
    input  xrmem_pkg::xr_word_t    xreg_rdata_i
);

    import xrmem_pkg::*;

    localparam int TILE_BANK_AW = `TILE_AWIDTH - 1;

    // host address decode
    logic        host_color;
    logic        host_tile;
    logic        host_copp;

    // write address decode
    logic        wr_regs;
    logic        wr_color;
    logic        wr_tile;
    logic        wr_copp;

    // arbitration
    logic        copp_accept;
    logic        host_rd_blocked;
    logic        host_accept;
    logic        host_rd;
    logic        wr_accept;
    xr_addr_t    wr_addr;
    xr_word_t    wr_data;

    // color RAM
    logic        color_rd_en;
    color_addr_t color_rd_addr;
    xr_word_t    color_rdata;
    logic        color_wr_en;

    // tile RAM banks
    logic        tile_rd_en;
    tile_addr_t  tile_rd_addr;
    xr_word_t    tile_lo_rdata;
    xr_word_t    tile_hi_rdata;
    xr_word_t    tile_rdata;
    logic        tile_bank_q;
    logic        tile_wr_en;

    // copper program RAM halves
    logic        copp_rd_en;
    copp_addr_t  copp_rd_addr;
    copp_word_t  copp_rdata;
    logic        copp_wr_en;

    // host read context for the ack cycle
    logic [2:0]  host_region_q;
    logic        host_odd_q;
    xr_word_t    xreg_rdata_q;

    assign host_color = (xr_addr_i[15:13] == `XR_COLOR_REGION);
    assign host_tile  = (xr_addr_i[15:13] == `XR_TILE_REGION);
    assign host_copp  = (xr_addr_i[15:13] == `XR_COPPER_REGION);

    // copper wins the write port, and only while its ack is low
    assign copp_accept = copp_xr_sel_i & ~copp_xr_ack_o;

    // host read waits while the video side owns that RAM's read port
    assign host_rd_blocked = ~xr_wr_i &
                             ((host_color & vgen_color_sel_i) |
                              (host_tile  & vgen_tile_sel_i)  |
                              (host_copp  & copp_prog_sel_i));

    assign host_accept = xr_sel_i & ~xr_ack_o & ~copp_accept & ~host_rd_blocked;
    assign host_rd     = host_accept & ~xr_wr_i;
    assign wr_accept   = copp_accept | (host_accept & xr_wr_i);

    // shared write path
    assign wr_addr = copp_accept ? copp_xr_addr_i : xr_addr_i;
    assign wr_data = copp_accept ? copp_xr_data_i : xr_data_i;

    assign wr_regs  = ~wr_addr[15];
    assign wr_color = (wr_addr[15:13] == `XR_COLOR_REGION);
    assign wr_tile  = (wr_addr[15:13] == `XR_TILE_REGION);
    assign wr_copp  = (wr_addr[15:13] == `XR_COPPER_REGION);

    // unmapped writes still ack but enable nothing
    assign color_wr_en = wr_accept & wr_color;
    assign tile_wr_en  = wr_accept & wr_tile;
    assign copp_wr_en  = wr_accept & wr_copp;

    // register bus follows the write address, which is the host address on host reads
    assign xreg_wr_o    = wr_accept & wr_regs;
    assign xreg_addr_o  = wr_addr;
    assign xreg_wdata_o = wr_data;

    // read ports, video address while its select is high
    assign color_rd_en   = vgen_color_sel_i | (host_rd & host_color);
    assign color_rd_addr = vgen_color_sel_i ? vgen_color_addr_i
                                            : xr_addr_i[`COLOR_AWIDTH-1:0];

    assign tile_rd_en   = vgen_tile_sel_i | (host_rd & host_tile);
    assign tile_rd_addr = vgen_tile_sel_i ? vgen_tile_addr_i
                                          : xr_addr_i[`TILE_AWIDTH-1:0];

    assign copp_rd_en   = copp_prog_sel_i | (host_rd & host_copp);
    assign copp_rd_addr = copp_prog_sel_i ? copp_prog_addr_i
                                          : xr_addr_i[`COPPER_AWIDTH:1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            xr_ack_o      <= 1'b0;
            copp_xr_ack_o <= 1'b0;
            tile_bank_q   <= 1'b0;
        end else begin
            xr_ack_o      <= host_accept;
            copp_xr_ack_o <= copp_accept;
            // bank of the word now sitting on the RAM outputs
            if (tile_rd_en) begin
                tile_bank_q <= tile_rd_addr[`TILE_AWIDTH-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd) begin
            host_region_q <= xr_addr_i[15:13];
            host_odd_q    <= xr_addr_i[0];
            xreg_rdata_q  <= xreg_rdata_i;
        end
    end

    assign tile_rdata = tile_bank_q ? tile_hi_rdata : tile_lo_rdata;

    assign vgen_color_data_o = color_rdata;
    assign vgen_tile_data_o  = tile_rdata;
    assign copp_prog_data_o  = copp_rdata;

    // host read result, valid in the ack cycle
    always_comb begin
        xr_data_o = '0;
        if (!host_region_q[2]) begin
            xr_data_o = xreg_rdata_q;
        end else begin
            case (host_region_q)
                `XR_COLOR_REGION: begin
                    xr_data_o = color_rdata;
                end
                `XR_TILE_REGION: begin
                    xr_data_o = tile_rdata;
                end
                `XR_COPPER_REGION: begin
                    xr_data_o = host_odd_q ? copp_rdata[`XR_DWIDTH-1:0]
                                           : copp_rdata[`COPP_DWIDTH-1:`XR_DWIDTH];
                end
                default: begin
                    xr_data_o = '0;
                end
            endcase
        end
    end

    xr_dpram #(
        .AWIDTH (`COLOR_AWIDTH),
        .DWIDTH (`XR_DWIDTH)
    ) color_ram (
        .clk       (clk),
        .rd_en_i   (color_rd_en),
        .rd_addr_i (color_rd_addr),
        .rd_data_o (color_rdata),
        .wr_en_i   (color_wr_en),
        .wr_addr_i (wr_addr[`COLOR_AWIDTH-1:0]),
        .wr_data_i (wr_data)
    );

    // tile bank 0, top tile address bit low
    xr_dpram #(
        .AWIDTH (TILE_BANK_AW),
        .DWIDTH (`XR_DWIDTH)
    ) tile_ram_lo (
        .clk       (clk),
        .rd_en_i   (tile_rd_en & ~tile_rd_addr[`TILE_AWIDTH-1]),
        .rd_addr_i (tile_rd_addr[TILE_BANK_AW-1:0]),
        .rd_data_o (tile_lo_rdata),
        .wr_en_i   (tile_wr_en & ~wr_addr[`TILE_AWIDTH-1]),
        .wr_addr_i (wr_addr[TILE_BANK_AW-1:0]),
        .wr_data_i (wr_data)
    );

    xr_dpram #(
        .AWIDTH (TILE_BANK_AW),
        .DWIDTH (`XR_DWIDTH)
    ) tile_ram_hi (
        .clk       (clk),
        .rd_en_i   (tile_rd_en & tile_rd_addr[`TILE_AWIDTH-1]),
        .rd_addr_i (tile_rd_addr[TILE_BANK_AW-1:0]),
        .rd_data_o (tile_hi_rdata),
        .wr_en_i   (tile_wr_en & wr_addr[`TILE_AWIDTH-1]),
        .wr_addr_i (wr_addr[TILE_BANK_AW-1:0]),
        .wr_data_i (wr_data)
    );

    // even XR addresses hold the upper instruction half
    xr_dpram #(
        .AWIDTH (`COPPER_AWIDTH),
        .DWIDTH (`XR_DWIDTH)
    ) copp_ram_even (
        .clk       (clk),
        .rd_en_i   (copp_rd_en),
        .rd_addr_i (copp_rd_addr),
        .rd_data_o (copp_rdata[`COPP_DWIDTH-1:`XR_DWIDTH]),
        .wr_en_i   (copp_wr_en & ~wr_addr[0]),
        .wr_addr_i (wr_addr[`COPPER_AWIDTH:1]),
        .wr_data_i (wr_data)
    );

    xr_dpram #(
        .AWIDTH (`COPPER_AWIDTH),
        .DWIDTH (`XR_DWIDTH)
    ) copp_ram_odd (
        .clk       (clk),
        .rd_en_i   (copp_rd_en),
        .rd_addr_i (copp_rd_addr),
        .rd_data_o (copp_rdata[`XR_DWIDTH-1:0]),
        .wr_en_i   (copp_wr_en & wr_addr[0]),
        .wr_addr_i (wr_addr[`COPPER_AWIDTH:1]),
        .wr_data_i (wr_data)
    );

endmodule

//--- src/xrmem_macros.svh
/* memory map region codes and memory sizes of the XR bus
   included by the package and by the modules that use them */

`ifndef XRMEM_MACROS_SVH
`define XRMEM_MACROS_SVH

// region codes matched against address bits 15..13
// bit 15 low means register file
// code 111 is unmapped
`define XR_COLOR_REGION     3'b100
`define XR_TILE_REGION      3'b101
`define XR_COPPER_REGION    3'b110

// memory address widths
`define COLOR_AWIDTH        8
`define TILE_AWIDTH         11
`define COPPER_AWIDTH       9

// data widths
`define XR_DWIDTH           16
`define COPP_DWIDTH         32

// number of XR registers
`define XREG_COUNT          16

`endif

//--- src/xrmem_pkg.sv
/* shared vector types of the XR memory side
   imported by the arbiter, the register file, the top level and the testbench */

`include "xrmem_macros.svh"

package xrmem_pkg;

    // address as seen on the host and copper XR ports
    // bits 15..13 pick the region
    typedef logic [15:0] xr_addr_t;

    // data word on every XR port and memory
    typedef logic [`XR_DWIDTH-1:0] xr_word_t;

    // one copper instruction
    // even half in the upper 16 bits
    typedef logic [`COPP_DWIDTH-1:0] copp_word_t;

    // color lookup index
    typedef logic [`COLOR_AWIDTH-1:0] color_addr_t;

    // tile address, top bit is the bank
    typedef logic [`TILE_AWIDTH-1:0] tile_addr_t;

    // copper program word address
    // one step per 32-bit instruction
    typedef logic [`COPPER_AWIDTH-1:0] copp_addr_t;

endpackage

//--- src/xrmem_top.sv
/* XR memory block top level
   joins the arbiter and its register file and exposes all requester ports */

`timescale 1ns/10ps

module xrmem_top (
    input  logic                   clk,
    input  logic                   arst_n_i,

    // host XR port
    input  logic                   xr_sel_i,
    input  logic                   xr_wr_i,
    input  xrmem_pkg::xr_addr_t    xr_addr_i,
    input  xrmem_pkg::xr_word_t    xr_data_i,
    output logic                   xr_ack_o,
    output xrmem_pkg::xr_word_t    xr_data_o,

    // copper XR port
    input  logic                   copp_xr_sel_i,
    input  xrmem_pkg::xr_addr_t    copp_xr_addr_i,
    input  xrmem_pkg::xr_word_t    copp_xr_data_i,
    output logic                   copp_xr_ack_o,

    // video read ports
    input  logic                   vgen_color_sel_i,
    input  xrmem_pkg::color_addr_t vgen_color_addr_i,
    output xrmem_pkg::xr_word_t    vgen_color_data_o,
    input  logic                   vgen_tile_sel_i,
    input  xrmem_pkg::tile_addr_t  vgen_tile_addr_i,
    output xrmem_pkg::xr_word_t    vgen_tile_data_o,
    input  logic                   copp_prog_sel_i,
    input  xrmem_pkg::copp_addr_t  copp_prog_addr_i,
    output xrmem_pkg::copp_word_t  copp_prog_data_o
);

    import xrmem_pkg::*;

    // register bus between arbiter and register file
    logic     xreg_wr;
    xr_addr_t xreg_addr;
    xr_word_t xreg_wdata;
    xr_word_t xreg_rdata;

    xrmem_arb u_arb (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .xr_sel_i          (xr_sel_i),
        .xr_wr_i           (xr_wr_i),
        .xr_addr_i         (xr_addr_i),
        .xr_data_i         (xr_data_i),
        .xr_ack_o          (xr_ack_o),
        .xr_data_o         (xr_data_o),
        .copp_xr_sel_i     (copp_xr_sel_i),
        .copp_xr_addr_i    (copp_xr_addr_i),
        .copp_xr_data_i    (copp_xr_data_i),
        .copp_xr_ack_o     (copp_xr_ack_o),
        .vgen_color_sel_i  (vgen_color_sel_i),
        .vgen_color_addr_i (vgen_color_addr_i),
        .vgen_color_data_o (vgen_color_data_o),
        .vgen_tile_sel_i   (vgen_tile_sel_i),
        .vgen_tile_addr_i  (vgen_tile_addr_i),
        .vgen_tile_data_o  (vgen_tile_data_o),
        .copp_prog_sel_i   (copp_prog_sel_i),
        .copp_prog_addr_i  (copp_prog_addr_i),
        .copp_prog_data_o  (copp_prog_data_o),
        .xreg_wr_o         (xreg_wr),
        .xreg_addr_o       (xreg_addr),
        .xreg_wdata_o      (xreg_wdata),
        .xreg_rdata_i      (xreg_rdata)
    );

    xreg_file u_xreg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (xreg_wr),
        .addr_i   (xreg_addr),
        .wdata_i  (xreg_wdata),
        .rdata_o  (xreg_rdata)
    );

endmodule

//--- testbench/tb_xrmem.sv
/* testbench for the XR memory block driven by a command file
   checks reads against the file and a shadow model of the memory map */

`timescale 1ns/10ps

`include "xrmem_macros.svh"

module tb_xrmem;

    import xrmem_pkg::*;

    localparam int STIM_WORDS = 320;
    // roughly ten times the cycles the command file needs
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        arst_n_i;
    logic        xr_sel_i;
    logic        xr_wr_i;
    xr_addr_t    xr_addr_i;
    xr_word_t    xr_data_i;
    logic        xr_ack_o;
    xr_word_t    xr_data_o;
    logic        copp_xr_sel_i;
    xr_addr_t    copp_xr_addr_i;
    xr_word_t    copp_xr_data_i;
    logic        copp_xr_ack_o;
    logic        vgen_color_sel_i;
    color_addr_t vgen_color_addr_i;
    xr_word_t    vgen_color_data_o;
    logic        vgen_tile_sel_i;
    tile_addr_t  vgen_tile_addr_i;
    xr_word_t    vgen_tile_data_o;
    logic        copp_prog_sel_i;
    copp_addr_t  copp_prog_addr_i;
    copp_word_t  copp_prog_data_o;

    // shadow of every region
    xr_word_t    reg_mem   [`XREG_COUNT];
    xr_word_t    color_mem [1 << `COLOR_AWIDTH];
    xr_word_t    tile_mem  [1 << `TILE_AWIDTH];
    xr_word_t    copp_mem  [2 << `COPPER_AWIDTH];

    logic [31:0] stim [STIM_WORDS];
    xr_addr_t    fill_addrs [$];
    integer      seed;
    integer      test_errors;
    integer      total_errors;
    integer      tests_passed;
    integer      tests_failed;
    integer      cycle_count;

    xrmem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: stimulus not finished after %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    function automatic void model_write(input xr_addr_t addr, input xr_word_t data);
        if (!addr[15]) begin
            reg_mem[addr[3:0]] = data;
        end else begin
            case (addr[15:13])
                `XR_COLOR_REGION:  color_mem[addr[`COLOR_AWIDTH-1:0]] = data;
                `XR_TILE_REGION:   tile_mem[addr[`TILE_AWIDTH-1:0]] = data;
                `XR_COPPER_REGION: copp_mem[addr[`COPPER_AWIDTH:0]] = data;
                default:           ;
            endcase
        end
    endfunction

    function automatic xr_word_t model_read(input xr_addr_t addr);
        if (!addr[15]) begin
            return reg_mem[addr[3:0]];
        end
        case (addr[15:13])
            `XR_COLOR_REGION:  return color_mem[addr[`COLOR_AWIDTH-1:0]];
            `XR_TILE_REGION:   return tile_mem[addr[`TILE_AWIDTH-1:0]];
            `XR_COPPER_REGION: return copp_mem[addr[`COPPER_AWIDTH:0]];
            default:           return 16'h0000;
        endcase
    endfunction

    // port codes 2 color, 3 tile, 4 copper program
    function automatic logic [31:0] video_model(input logic [3:0] port, input xr_addr_t addr);
        case (port)
            4'h2:    return {16'h0, color_mem[addr[`COLOR_AWIDTH-1:0]]};
            4'h3:    return {16'h0, tile_mem[addr[`TILE_AWIDTH-1:0]]};
            default: return {copp_mem[{addr[`COPPER_AWIDTH-1:0], 1'b0}],
                             copp_mem[{addr[`COPPER_AWIDTH-1:0], 1'b1}]};
        endcase
    endfunction

    task host_access(input logic wr, input xr_addr_t addr, input xr_word_t data,
                     output xr_word_t rdata);
        @(negedge clk);
        xr_sel_i  = 1'b1;
        xr_wr_i   = wr;
        xr_addr_i = addr;
        xr_data_i = data;
        @(negedge clk);
        while (!xr_ack_o) @(negedge clk);
        rdata    = xr_data_o;
        xr_sel_i = 1'b0;
        xr_wr_i  = 1'b0;
    endtask

    task copper_write(input xr_addr_t addr, input xr_word_t data);
        @(negedge clk);
        copp_xr_sel_i  = 1'b1;
        copp_xr_addr_i = addr;
        copp_xr_data_i = data;
        @(negedge clk);
        while (!copp_xr_ack_o) @(negedge clk);
        copp_xr_sel_i = 1'b0;
    endtask

    task video_read(input logic [3:0] port, input xr_addr_t addr, output logic [31:0] got);
        @(negedge clk);
        case (port)
            4'h2: begin
                vgen_color_sel_i  = 1'b1;
                vgen_color_addr_i = addr[`COLOR_AWIDTH-1:0];
            end
            4'h3: begin
                vgen_tile_sel_i  = 1'b1;
                vgen_tile_addr_i = addr[`TILE_AWIDTH-1:0];
            end
            default: begin
                copp_prog_sel_i  = 1'b1;
                copp_prog_addr_i = addr[`COPPER_AWIDTH-1:0];
            end
        endcase
        // registered RAM output one cycle later
        @(negedge clk);
        case (port)
            4'h2:    got = {16'h0, vgen_color_data_o};
            4'h3:    got = {16'h0, vgen_tile_data_o};
            default: got = copp_prog_data_o;
        endcase
        vgen_color_sel_i = 1'b0;
        vgen_tile_sel_i  = 1'b0;
        copp_prog_sel_i  = 1'b0;
    endtask

    // copper writes caddr and host writes caddr + 1 in the same cycle
    task collide(input xr_addr_t caddr, input xr_word_t cdata, input xr_word_t hdata);
        integer cyc;
        integer copp_at;
        integer host_at;
        @(negedge clk);
        copp_xr_sel_i  = 1'b1;
        copp_xr_addr_i = caddr;
        copp_xr_data_i = cdata;
        xr_sel_i       = 1'b1;
        xr_wr_i        = 1'b1;
        xr_addr_i      = caddr + 16'd1;
        xr_data_i      = hdata;
        cyc     = 0;
        copp_at = -1;
        host_at = -1;
        while (copp_at < 0 || host_at < 0) begin
            @(negedge clk);
            cyc++;
            if (copp_xr_ack_o) begin
                copp_at       = cyc;
                copp_xr_sel_i = 1'b0;
            end
            if (xr_ack_o) begin
                host_at  = cyc;
                xr_sel_i = 1'b0;
                xr_wr_i  = 1'b0;
            end
        end
        check_value(copp_at, 1, "copper ack cycle");
        check_value(host_at, 2, "host ack cycle after copper ack");
        model_write(caddr, cdata);
        model_write(caddr + 16'd1, hdata);
    endtask

    // video tile select held four cycles while the host reads haddr
    task hold_video_tile(input xr_addr_t haddr, input tile_addr_t vaddr, input xr_word_t hexp);
        integer i;
        xr_word_t got;
        @(negedge clk);
        xr_sel_i         = 1'b1;
        xr_wr_i          = 1'b0;
        xr_addr_i        = haddr;
        vgen_tile_sel_i  = 1'b1;
        vgen_tile_addr_i = vaddr;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value({31'h0, xr_ack_o}, 32'h0, "host ack while video tile select high");
            check_value({16'h0, vgen_tile_data_o}, {16'h0, tile_mem[vgen_tile_addr_i]},
                        $sformatf("video tile data at %h", vgen_tile_addr_i));
            vgen_tile_addr_i = vgen_tile_addr_i + 11'd1;
        end
        vgen_tile_sel_i = 1'b0;
        @(negedge clk);
        while (!xr_ack_o) @(negedge clk);
        got      = xr_data_o;
        xr_sel_i = 1'b0;
        check_value({16'h0, got}, {16'h0, hexp}, "held host tile read vs stimulus");
        check_value({16'h0, got}, {16'h0, model_read(haddr)}, "held host tile read vs model");
    endtask

    // one region per write in turn with port and data from $random
    task random_fill(input integer count);
        integer      i;
        logic [31:0] rnd;
        xr_addr_t    addr;
        xr_word_t    got;
        fill_addrs.delete();
        for (i = 0; i < count; i++) begin
            rnd = $random(seed);
            case (i % 5)
                0:       addr = {1'b0, rnd[14:0]};
                1:       addr = {`XR_COLOR_REGION, 5'b0, rnd[7:0]};
                2:       addr = {`XR_TILE_REGION, 2'b0, rnd[10:0]};
                3:       addr = {`XR_COPPER_REGION, 3'b0, rnd[9:0]};
                default: addr = {3'b111, rnd[12:0]};
            endcase
            if (rnd[15]) begin
                copper_write(addr, rnd[31:16]);
            end else begin
                host_access(1'b1, addr, rnd[31:16], got);
            end
            model_write(addr, rnd[31:16]);
            fill_addrs.push_back(addr);
        end
        for (i = 0; i < fill_addrs.size(); i++) begin
            host_access(1'b0, fill_addrs[i], 16'h0, got);
            check_value({16'h0, got}, {16'h0, model_read(fill_addrs[i])},
                        $sformatf("fill readback at %h", fill_addrs[i]));
        end
    endtask

    task end_test(input integer num);
        if (test_errors == 0) begin
            $display("test %0d passed", num);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        integer      p;
        logic [3:0]  op;
        logic [3:0]  port;
        xr_addr_t    addr;
        xr_word_t    data;
        xr_word_t    got;
        logic [31:0] expv;
        logic [31:0] vgot;
        arst_n_i          = 1'b0;
        xr_sel_i          = 1'b0;
        xr_wr_i           = 1'b0;
        xr_addr_i         = '0;
        xr_data_i         = '0;
        copp_xr_sel_i     = 1'b0;
        copp_xr_addr_i    = '0;
        copp_xr_data_i    = '0;
        vgen_color_sel_i  = 1'b0;
        vgen_color_addr_i = '0;
        vgen_tile_sel_i   = 1'b0;
        vgen_tile_addr_i  = '0;
        copp_prog_sel_i   = 1'b0;
        copp_prog_addr_i  = '0;
        seed         = 74;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        // register file clears on reset
        for (p = 0; p < `XREG_COUNT; p++) begin
            reg_mem[p] = '0;
        end
        for (p = 0; p < STIM_WORDS; p++) begin
            stim[p] = '0;
        end
        $readmemh("testbench/xrmem_stimulus.txt", stim);

        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // five words per command
        // op code 0 ends the list
        p = 0;
        while (p < STIM_WORDS && stim[p] != 0) begin
            op   = stim[p][3:0];
            port = stim[p+1][3:0];
            addr = stim[p+2][15:0];
            data = stim[p+3][15:0];
            expv = stim[p+4];
            case (op)
                4'h1: begin
                    if (port == 4'h1) begin
                        copper_write(addr, data);
                    end else begin
                        host_access(1'b1, addr, data, got);
                    end
                    model_write(addr, data);
                end
                4'h2: begin
                    host_access(1'b0, addr, 16'h0, got);
                    check_value({16'h0, got}, expv, $sformatf("host read %h vs stimulus", addr));
                    check_value({16'h0, got}, {16'h0, model_read(addr)},
                                $sformatf("host read %h vs model", addr));
                end
                4'h3: begin
                    video_read(port, addr, vgot);
                    check_value(vgot, expv, $sformatf("video read %h vs stimulus", addr));
                    check_value(vgot, video_model(port, addr),
                                $sformatf("video read %h vs model", addr));
                end
                4'h4: collide(addr, data, expv[15:0]);
                4'h5: hold_video_tile(addr, stim[p+3][`TILE_AWIDTH-1:0], expv[15:0]);
                4'h6: random_fill(stim[p+3]);
                4'h7: end_test(stim[p+2]);
                default: begin
                    $display("unknown command code %h in stimulus word %0d", op, p);
                    test_errors++;
                    total_errors++;
                end
            endcase
            p = p + 5;
        end

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors == 0 && tests_passed > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/xrmem_stimulus.txt
// columns: op port addr data expect (hex); op 1 write 2 host read 3 video read
// 4 collision 5 video hold 6 random fill 7 end; port 0 host 1 copper 2 color 3 tile 4 program
// test 1: registers and unmapped space read zero after reset
2 0 0000 0000 00000000
2 0 0005 0000 00000000
2 0 000f 0000 00000000
2 0 e123 0000 00000000
7 0 0001 0000 00000000
// test 2: write and read back in every region
1 0 0003 1234 00000000
2 0 0003 0000 00001234
2 0 0013 0000 00001234
1 0 8042 c0fe 00000000
2 0 8042 0000 0000c0fe
1 0 a010 0a10 00000000
2 0 a010 0000 00000a10
1 0 a410 4a10 00000000
2 0 a410 0000 00004a10
1 0 c020 ee20 00000000
1 0 c021 dd21 00000000
2 0 c020 0000 0000ee20
2 0 c021 0000 0000dd21
7 0 0002 0000 00000000
// test 3: copper halves joined on the program port
1 0 c040 1111 00000000
1 1 c041 2222 00000000
2 0 c040 0000 00001111
3 4 0020 0000 11112222
3 4 0010 0000 ee20dd21
7 0 0003 0000 00000000
// test 4: copper color write at addr, host at addr + 1 with the last column as data
4 1 8050 aaaa 00005555
2 0 8050 0000 0000aaaa
2 0 8051 0000 00005555
7 0 0004 0000 00000000
// test 5: video tile reads from data column onward hold off the host read
1 0 a100 0100 00000000
1 0 a101 0101 00000000
1 0 a102 0102 00000000
1 0 a103 0103 00000000
5 3 a410 0100 00004a10
3 3 0101 0000 00000101
3 2 0042 0000 0000c0fe
7 0 0005 0000 00000000
// test 6: random fill of 40 words, then host readback
6 0 0000 0028 00000000
7 0 0006 0000 00000000

//--- xrmem.f
+incdir+src
src/xrmem_pkg.sv
src/xr_dpram.sv
src/xreg_file.sv
src/xrmem_arb.sv
src/xrmem_top.sv
testbench/tb_xrmem.sv
